/* hw/mcu_bridge_pkg.sv */
package mcu_bridge_pkg;

    ////////////////////////////////////////
    // Protocol encodings
    ////////////////////////////////////////

    typedef enum logic [7:0] {
        CMD_IDENTIFY  = 8'd0,
        CMD_REG_READ  = 8'd1,
        CMD_REG_WRITE = 8'd2,
        CMD_MEM_READ  = 8'd3,
        CMD_MEM_WRITE = 8'd4
    } cmd_e;

    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_ADDRESS,
        PHASE_DATA,
        PHASE_NOP
    } phase_e;

    // Sparse map. Holes read as zero.
    typedef enum logic [7:0] {
        REG_MEM_ADDRESS    = 8'd0,
        REG_MEM_SCR        = 8'd1,
        REG_CFG_SCR        = 8'd6,
        REG_CFG_IDENTIFIER = 8'd10,
        REG_CIC_0          = 8'd37,
        REG_CIC_1          = 8'd38
    } reg_addr_e;

    ////////////////////////////////////////
    // Constants
    ////////////////////////////////////////

    localparam logic [7:0]  FPGA_ID            = 8'h64;
    localparam logic [31:0] CFG_IDENTIFIER     = 32'h53437632;
    localparam logic [7:0]  CIC_SEED_RESET     = 8'h3F;
    localparam logic [47:0] CIC_CHECKSUM_RESET = 48'hA536C0F1D859;

    localparam int CFG_BOOTLOADER_ENABLED = 0;
    localparam int CFG_BOOTLOADER_SKIP    = 1;

endpackage

/* hw/mcu_bridge_ifs.sv */
`timescale 1ns/10ps

////////////////////////////////////////
// Register access
////////////////////////////////////////

interface reg_access_if;

    logic        read;
    logic        write;
    logic [7:0]  address;
    logic [31:0] wdata;
    logic [31:0] rdata;    // Valid the cycle after read.

    modport decoder (
        output read,
        output write,
        output address,
        output wdata
    );

    modport target (
        input  read,
        input  write,
        input  address,
        input  wdata,
        output rdata
    );

endinterface

////////////////////////////////////////
// Transfer buffer access
////////////////////////////////////////

interface buf_access_if #(
    parameter int BUF_ADDR_W = 9
);

    logic                  read;
    logic                  write;
    logic [BUF_ADDR_W-2:0] address;    // Word pair, low index bit is word_select.
    logic                  word_select;
    logic [15:0]           wdata;
    logic [15:0]           rdata;

    modport decoder (
        output read,
        output write,
        output address,
        output word_select,
        output wdata
    );

    modport target (
        input  read,
        input  write,
        input  address,
        input  word_select,
        input  wdata,
        output rdata
    );

endinterface

////////////////////////////////////////
// Memory transfer control
////////////////////////////////////////

interface mem_ctrl_if #(
    parameter int MEM_ADDR_W = 32
);

    logic                  start;    // One cycle pulse.
    logic                  stop;     // One cycle pulse.
    logic                  direction;
    logic [9:0]            length;   // Words.
    logic [MEM_ADDR_W-1:0] address;
    logic                  busy;

    modport control (
        output start,
        output stop,
        output direction,
        output length,
        output address,
        input  busy
    );

    modport engine (
        input  start,
        input  stop,
        input  direction,
        input  length,
        input  address,
        output busy
    );

endinterface

/* hw/mcu_cmd_decoder.sv */
`timescale 1ns/10ps

module mcu_cmd_decoder (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frame_start,
    input  logic                 data_ready,
    input  logic [7:0]           rx_data,
    output mcu_bridge_pkg::cmd_e cmd,
    output logic [1:0]           byte_count,
    reg_access_if.decoder        reg_bus,
    buf_access_if.decoder        buf_bus
);

    import mcu_bridge_pkg::*;

    localparam int BUF_PAIR_W = $bits(buf_bus.address);

    phase_e     phase;
    logic [7:0] address;

    assign reg_bus.address = address;
    assign buf_bus.address = BUF_PAIR_W'(address);

    always_ff @(posedge clk) begin
        reg_bus.read  <= 1'b0;
        reg_bus.write <= 1'b0;
        buf_bus.read  <= 1'b0;
        buf_bus.write <= 1'b0;

        if (reset) begin
            phase      <= PHASE_NOP;
            cmd        <= CMD_IDENTIFY;
            byte_count <= 2'd0;
        end else begin
            if (frame_start) begin
                byte_count <= 2'd0;
                phase      <= PHASE_CMD;
            end

            // Step after every register and after the odd word of a pair.
            if (reg_bus.read || reg_bus.write ||
                (buf_bus.word_select && (buf_bus.read || buf_bus.write))) begin
                address <= address + 8'd1;
            end

            if (data_ready) begin
                case (phase)
                    PHASE_CMD: begin
                        cmd   <= cmd_e'(rx_data);
                        phase <= PHASE_ADDRESS;
                    end

                    PHASE_ADDRESS: begin
                        address <= rx_data;
                        phase   <= PHASE_DATA;
                        if (cmd == CMD_REG_READ) begin
                            reg_bus.read <= 1'b1;
                        end
                        if (cmd == CMD_MEM_READ) begin
                            buf_bus.read        <= 1'b1;
                            buf_bus.word_select <= 1'b0;
                        end
                    end

                    PHASE_DATA: begin
                        byte_count <= byte_count + 2'd1;

                        // Prefetch the next word for the following bytes.
                        if (cmd == CMD_REG_READ && byte_count == 2'd3) begin
                            reg_bus.read <= 1'b1;
                        end

                        if (cmd == CMD_REG_WRITE) begin
                            reg_bus.wdata[{byte_count, 3'b000} +: 8] <= rx_data;    // LSB first.
                            if (byte_count == 2'd3) begin
                                reg_bus.write <= 1'b1;
                            end
                        end

                        if (cmd == CMD_MEM_READ && byte_count[0]) begin
                            buf_bus.read        <= 1'b1;
                            buf_bus.word_select <= ~buf_bus.word_select;
                        end

                        if (cmd == CMD_MEM_WRITE) begin
                            if (byte_count[0]) begin
                                buf_bus.wdata[7:0]  <= rx_data;
                                buf_bus.write       <= 1'b1;
                                buf_bus.word_select <= byte_count[1];
                            end else begin
                                buf_bus.wdata[15:8] <= rx_data;    // High byte first.
                            end
                        end
                    end

                    PHASE_NOP: begin
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

/* hw/mcu_reg_block.sv */
`timescale 1ns/10ps

module mcu_reg_block (
    input  logic          clk,
    input  logic          reset,
    input  logic          n64_nmi,
    input  logic          cic_invalid_region_in,
    output logic [11:0]   cfg_flags,
    output logic          cic_disabled,
    output logic          cic_64dd_mode,
    output logic          cic_region,
    output logic [7:0]    cic_seed,
    output logic [47:0]   cic_checksum,
    reg_access_if.target  reg_bus,
    mem_ctrl_if.control   mem_ctrl
);

    import mcu_bridge_pkg::*;

    localparam int BUS_ADDR_W = $bits(mem_ctrl.address);

    logic [31:0] mem_address;
    logic        cic_invalid_region;    // Sticky.

    assign mem_ctrl.address = BUS_ADDR_W'(mem_address);

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reg_bus.read) begin
            case (reg_addr_e'(reg_bus.address))
                REG_MEM_ADDRESS:    reg_bus.rdata <= mem_address;
                REG_MEM_SCR:        reg_bus.rdata <= {28'd0, mem_ctrl.busy, 3'b000};
                REG_CFG_SCR:        reg_bus.rdata <= {20'd0, cfg_flags};
                REG_CFG_IDENTIFIER: reg_bus.rdata <= CFG_IDENTIFIER;
                REG_CIC_0: begin
                    reg_bus.rdata <= {
                        3'd0,
                        cic_invalid_region,
                        1'b0,
                        cic_disabled,
                        cic_64dd_mode,
                        cic_region,
                        cic_seed,
                        cic_checksum[47:32]
                    };
                end
                REG_CIC_1:          reg_bus.rdata <= cic_checksum[31:0];
                default:            reg_bus.rdata <= 32'd0;
            endcase
        end
    end

    ////////////////////////////////////////
    // Write path
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        mem_ctrl.start <= 1'b0;
        mem_ctrl.stop  <= 1'b0;

        if (n64_nmi) begin
            cfg_flags[CFG_BOOTLOADER_ENABLED] <= ~cfg_flags[CFG_BOOTLOADER_SKIP];
        end

        if (cic_invalid_region_in) begin
            cic_invalid_region <= 1'b1;
        end

        if (reset) begin
            cfg_flags                         <= 12'd0;
            cfg_flags[CFG_BOOTLOADER_ENABLED] <= 1'b1;
            mem_address                       <= 32'd0;
            mem_ctrl.direction                <= 1'b0;
            mem_ctrl.length                   <= 10'd0;
            cic_invalid_region                <= 1'b0;
            cic_disabled                      <= 1'b0;
            cic_64dd_mode                     <= 1'b0;
            cic_region                        <= 1'b0;
            cic_seed                          <= CIC_SEED_RESET;
            cic_checksum                      <= CIC_CHECKSUM_RESET;
        end else if (reg_bus.write) begin
            case (reg_addr_e'(reg_bus.address))
                REG_MEM_ADDRESS: mem_address <= reg_bus.wdata;
                REG_MEM_SCR: begin
                    {mem_ctrl.length, mem_ctrl.direction, mem_ctrl.stop, mem_ctrl.start} <=
                        {reg_bus.wdata[14:5], reg_bus.wdata[2:0]};
                end
                REG_CFG_SCR:     cfg_flags <= reg_bus.wdata[11:0];
                REG_CIC_0: begin
                    if (reg_bus.wdata[28]) begin
                        cic_invalid_region <= 1'b0;    // Write one to clear.
                    end
                    cic_disabled          <= reg_bus.wdata[26];
                    cic_64dd_mode         <= reg_bus.wdata[25];
                    cic_region            <= reg_bus.wdata[24];
                    cic_seed              <= reg_bus.wdata[23:16];
                    cic_checksum[47:32]   <= reg_bus.wdata[15:0];
                end
                REG_CIC_1:       cic_checksum[31:0] <= reg_bus.wdata;
                default: begin
                end
            endcase
        end
    end

endmodule

/* hw/mem_buffer_ctrl.sv */
`timescale 1ns/10ps

module mem_buffer_ctrl #(
    parameter int BUF_ADDR_W = 9,
    parameter int MEM_ADDR_W = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    buf_access_if.target          buf_bus,
    mem_ctrl_if.engine            mem_ctrl,
    output logic                  mem_request,
    output logic                  mem_write,
    output logic [MEM_ADDR_W-1:0] mem_address,
    output logic [15:0]           mem_wdata,
    input  logic                  mem_ack,
    input  logic [15:0]           mem_rdata
);

    logic [15:0] buffer [2**BUF_ADDR_W];

    logic                  busy;
    logic                  stop_pending;
    logic [9:0]            word_count;
    logic [BUF_ADDR_W-1:0] buf_index;
    logic [BUF_ADDR_W-1:0] engine_index;
    logic                  bus_done;

    assign buf_index     = {buf_bus.address, buf_bus.word_select};
    assign engine_index  = BUF_ADDR_W'(word_count);    // Transfers start at word 0.
    assign bus_done      = mem_request && mem_ack;
    assign mem_ctrl.busy = busy;

    ////////////////////////////////////////
    // Buffer RAM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (buf_bus.read) begin
            buf_bus.rdata <= buffer[buf_index];
        end
        if (buf_bus.write) begin
            buffer[buf_index] <= buf_bus.wdata;
        end
        if (bus_done && !mem_write) begin
            buffer[engine_index] <= mem_rdata;
        end
    end

    ////////////////////////////////////////
    // Transfer engine
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            busy         <= 1'b0;
            stop_pending <= 1'b0;
            mem_request  <= 1'b0;
        end else begin
            if (mem_ctrl.stop) begin
                stop_pending <= busy;
            end else if (mem_ctrl.start && !busy) begin
                mem_write   <= mem_ctrl.direction;
                mem_address <= mem_ctrl.address;
                word_count  <= 10'd0;
                busy        <= 1'b1;
            end

            if (busy) begin
                // Gap of one idle cycle after each ack.
                if (!mem_request) begin
                    mem_request <= 1'b1;
                    mem_wdata   <= buffer[engine_index];
                end

                if (bus_done) begin
                    mem_request <= 1'b0;
                    mem_address <= mem_address + MEM_ADDR_W'(2);
                    word_count  <= word_count + 10'd1;
                    if (word_count == mem_ctrl.length - 10'd1 || stop_pending) begin
                        busy         <= 1'b0;
                        stop_pending <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

/* hw/mcu_response_mux.sv */
`timescale 1ns/10ps

module mcu_response_mux (
    input  mcu_bridge_pkg::cmd_e cmd,
    input  logic [1:0]           byte_count,
    input  logic [31:0]          reg_rdata,
    input  logic [15:0]          buf_rdata,
    output logic [7:0]           tx_data
);

    import mcu_bridge_pkg::*;

    always_comb begin
        tx_data = 8'h00;

        case (cmd)
            CMD_IDENTIFY: begin
                tx_data = FPGA_ID;
            end

            CMD_REG_READ: begin
                tx_data = reg_rdata[{byte_count, 3'b000} +: 8];    // LSB first.
            end

            CMD_MEM_READ: begin
                tx_data = byte_count[0] ? buf_rdata[7:0] : buf_rdata[15:8];
            end

            default: begin
                tx_data = 8'h00;
            end
        endcase
    end

endmodule

/* hw/mcu_bridge_top.sv */
`timescale 1ns/10ps

module mcu_bridge_top #(
    parameter int BUF_ADDR_W = 9,
    parameter int MEM_ADDR_W = 32
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  frame_start,
    input  logic                  data_ready,
    input  logic [7:0]            rx_data,
    output logic [7:0]            tx_data,

    output logic                  mem_request,
    input  logic                  mem_ack,
    output logic                  mem_write,
    output logic [MEM_ADDR_W-1:0] mem_address,
    output logic [15:0]           mem_wdata,
    input  logic [15:0]           mem_rdata,

    input  logic                  n64_nmi,
    input  logic                  cic_invalid_region_in,
    output logic [11:0]           cfg_flags,
    output logic                  cic_disabled,
    output logic                  cic_64dd_mode,
    output logic                  cic_region,
    output logic [7:0]            cic_seed,
    output logic [47:0]           cic_checksum
);

    import mcu_bridge_pkg::*;

    cmd_e       cmd;
    logic [1:0] byte_count;

    reg_access_if                              reg_bus ();
    buf_access_if #(.BUF_ADDR_W(BUF_ADDR_W))   buf_bus ();
    mem_ctrl_if   #(.MEM_ADDR_W(MEM_ADDR_W))   mem_ctrl ();

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    mcu_cmd_decoder u_decoder (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .data_ready  (data_ready),
        .rx_data     (rx_data),
        .cmd         (cmd),
        .byte_count  (byte_count),
        .reg_bus     (reg_bus.decoder),
        .buf_bus     (buf_bus.decoder)
    );

    ////////////////////////////////////////
    // Execute
    ////////////////////////////////////////

    mcu_reg_block u_reg_block (
        .clk                   (clk),
        .reset                 (reset),
        .n64_nmi               (n64_nmi),
        .cic_invalid_region_in (cic_invalid_region_in),
        .cfg_flags             (cfg_flags),
        .cic_disabled          (cic_disabled),
        .cic_64dd_mode         (cic_64dd_mode),
        .cic_region            (cic_region),
        .cic_seed              (cic_seed),
        .cic_checksum          (cic_checksum),
        .reg_bus               (reg_bus.target),
        .mem_ctrl              (mem_ctrl.control)
    );

    mem_buffer_ctrl #(
        .BUF_ADDR_W (BUF_ADDR_W),
        .MEM_ADDR_W (MEM_ADDR_W)
    ) u_buffer_ctrl (
        .clk         (clk),
        .reset       (reset),
        .buf_bus     (buf_bus.target),
        .mem_ctrl    (mem_ctrl.engine),
        .mem_request (mem_request),
        .mem_write   (mem_write),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata)
    );

    ////////////////////////////////////////
    // Result
    ////////////////////////////////////////

    mcu_response_mux u_response_mux (
        .cmd        (cmd),
        .byte_count (byte_count),
        .reg_rdata  (reg_bus.rdata),
        .buf_rdata  (buf_bus.rdata),
        .tx_data    (tx_data)
    );

endmodule

/* include/tb_frames.svh */
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

////////////////////////////////////////
// Frame transport
////////////////////////////////////////

logic [15:0] buffer_words [$];    // Filled by read_buffer.

task automatic start_frame();
    frame_start = 1'b1;
    @(negedge clk);
    frame_start = 1'b0;
    @(negedge clk);
endtask

// One byte, then the gap the transport keeps before the next one.
task automatic send_byte(input logic [7:0] value);
    rx_data    = value;
    data_ready = 1'b1;
    @(negedge clk);
    data_ready = 1'b0;
    repeat (BYTE_GAP - 1) @(negedge clk);
endtask

task automatic open_frame(input logic [7:0] cmd, input logic [7:0] address);
    start_frame();
    send_byte(cmd);
    send_byte(address);
endtask

task automatic send_word(input logic [31:0] value);
    int b;
    for (b = 0; b < 4; b++) begin
        send_byte(value[8 * b +: 8]);    // LSB first.
    end
endtask

task automatic write_reg(input logic [7:0] address, input logic [31:0] value);
    open_frame(CMD_REG_WRITE, address);
    send_word(value);
endtask

// Second word lands one register above the first.
task automatic write_reg_pair(input logic [7:0] address, input logic [31:0] first,
                              input logic [31:0] second);
    open_frame(CMD_REG_WRITE, address);
    send_word(first);
    send_word(second);
endtask

task automatic read_reg(input logic [7:0] address, output logic [31:0] value);
    int b;
    open_frame(CMD_REG_READ, address);
    for (b = 0; b < 4; b++) begin
        value[8 * b +: 8] = tx_data;
        send_byte(8'h00);
    end
endtask

task automatic write_buffer(input logic [7:0] pair_address, input logic [15:0] words [$]);
    open_frame(CMD_MEM_WRITE, pair_address);
    foreach (words[k]) begin
        send_byte(words[k][15:8]);    // High byte first.
        send_byte(words[k][7:0]);
    end
endtask

task automatic read_buffer(input logic [7:0] pair_address, input int count);
    logic [15:0] value;
    int          k;
    buffer_words.delete();
    open_frame(CMD_MEM_READ, pair_address);
    for (k = 0; k < count; k++) begin
        value[15:8] = tx_data;
        send_byte(8'h00);
        value[7:0] = tx_data;
        send_byte(8'h00);
        buffer_words.push_back(value);
    end
endtask

////////////////////////////////////////
// Memory bus responder
////////////////////////////////////////

logic [31:0] bus_addr_q  [$];
logic [15:0] bus_data_q  [$];
logic        bus_write_q [$];

initial begin : bus_responder
    int delay;
    mem_ack   = 1'b0;
    mem_rdata = 16'h0000;
    forever begin
        @(negedge clk);
        if (!reset && mem_request) begin
            bus_addr_q.push_back(mem_address);
            bus_data_q.push_back(mem_wdata);
            bus_write_q.push_back(mem_write);
            delay = int'($urandom_range(4, 1));
            repeat (delay - 1) @(negedge clk);
            mem_rdata = mem_address[15:0] ^ 16'h5A5A;    // Address derived data.
            mem_ack   = 1'b1;
            @(negedge clk);
            mem_ack   = 1'b0;
        end
    end
end

`endif

/* tb/mcu_bridge_tb.sv */
`timescale 1ns/10ps

module mcu_bridge_tb;

    localparam logic [7:0] CMD_IDENTIFY  = 8'd0;
    localparam logic [7:0] CMD_REG_READ  = 8'd1;
    localparam logic [7:0] CMD_REG_WRITE = 8'd2;
    localparam logic [7:0] CMD_MEM_READ  = 8'd3;
    localparam logic [7:0] CMD_MEM_WRITE = 8'd4;

    localparam logic [7:0] ADDR_MEM_ADDRESS = 8'd0;
    localparam logic [7:0] ADDR_MEM_SCR     = 8'd1;
    localparam logic [7:0] ADDR_CFG_SCR     = 8'd6;
    localparam logic [7:0] ADDR_CFG_ID      = 8'd10;
    localparam logic [7:0] ADDR_CIC_0       = 8'd37;
    localparam logic [7:0] ADDR_CIC_1       = 8'd38;

    localparam int BYTE_GAP   = 6;
    localparam int IDLE_POLLS = 40;
    localparam int XFER_WORDS = 12;
    localparam int LONG_WORDS = 100;

    logic        clk;
    logic        reset;
    logic        frame_start;
    logic        data_ready;
    logic [7:0]  rx_data;
    logic [7:0]  tx_data;
    logic        mem_request;
    logic        mem_ack;
    logic        mem_write;
    logic [31:0] mem_address;
    logic [15:0] mem_wdata;
    logic [15:0] mem_rdata;
    logic        n64_nmi;
    logic        cic_invalid_region_in;
    logic [11:0] cfg_flags;
    logic        cic_disabled;
    logic        cic_64dd_mode;
    logic        cic_region;
    logic [7:0]  cic_seed;
    logic [47:0] cic_checksum;

    int tests_run;
    int failed_tests;
    int test_errors;

    mcu_bridge_top #(
        .BUF_ADDR_W (9),
        .MEM_ADDR_W (32)
    ) dut (
        .clk                   (clk),
        .reset                 (reset),
        .frame_start           (frame_start),
        .data_ready            (data_ready),
        .rx_data               (rx_data),
        .tx_data               (tx_data),
        .mem_request           (mem_request),
        .mem_ack               (mem_ack),
        .mem_write             (mem_write),
        .mem_address           (mem_address),
        .mem_wdata             (mem_wdata),
        .mem_rdata             (mem_rdata),
        .n64_nmi               (n64_nmi),
        .cic_invalid_region_in (cic_invalid_region_in),
        .cfg_flags             (cfg_flags),
        .cic_disabled          (cic_disabled),
        .cic_64dd_mode         (cic_64dd_mode),
        .cic_region            (cic_region),
        .cic_seed              (cic_seed),
        .cic_checksum          (cic_checksum)
    );

    `include "tb_frames.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // Checking and reporting
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        assert (actual === expected) else begin
            $display("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS  %s", name);
        end else begin
            $display("FAIL  %s (%0d errors)", name, test_errors);
            failed_tests++;
        end
    endtask

    ////////////////////////////////////////
    // Transfer helpers
    ////////////////////////////////////////

    // Memory status word: length in 14:5, direction, stop, start in 2:0.
    function automatic logic [31:0] scr_value(input int length, input logic direction,
                                              input logic stop, input logic start);
        return {17'd0, 10'(length), 2'b00, direction, stop, start};
    endfunction

    task automatic clear_bus_log();
        bus_addr_q.delete();
        bus_data_q.delete();
        bus_write_q.delete();
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = 32'h8;
        while (status[3] && polls < IDLE_POLLS) begin
            read_reg(ADDR_MEM_SCR, status);
            polls++;
        end
        assert (!status[3]) else begin
            $display("Transfer still busy after %0d status polls", polls);
            test_errors++;
        end
    endtask

    task automatic run_transfer(input logic [31:0] base, input int length,
                                input logic direction);
        clear_bus_log();
        write_reg_pair(ADDR_MEM_ADDRESS, base, scr_value(length, direction, 1'b0, 1'b1));
        wait_idle();
    endtask

    // Every logged request steps the bus address by 2.
    task automatic check_requests(input logic [31:0] base, input logic direction);
        int k;
        for (k = 0; k < bus_addr_q.size(); k++) begin
            check_value("mem_address", 64'(bus_addr_q[k]), 64'(base + 32'(2 * k)));
            check_value("mem_write", 64'(bus_write_q[k]), 64'(direction));
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_identify();
        logic [31:0] value;
        test_errors = 0;
        read_reg(ADDR_CFG_ID, value);
        check_value("CFG_IDENTIFIER", 64'(value), 64'h5343_7632);
        start_frame();
        send_byte(CMD_IDENTIFY);
        check_value("tx_data", 64'(tx_data), 64'h64);
        finish_test("identify");
    endtask

    task automatic test_reset_values();
        logic [31:0] value;
        test_errors = 0;
        read_reg(ADDR_CIC_0, value);
        check_value("CIC_0", 64'(value), 64'h003F_A536);
        read_reg(ADDR_CIC_1, value);
        check_value("CIC_1", 64'(value), 64'hC0F1_D859);
        check_value("cic_seed", 64'(cic_seed), 64'h3F);
        check_value("cic_checksum", 64'(cic_checksum), 64'hA536_C0F1_D859);
        check_value("cfg_flags", 64'(cfg_flags), 64'h001);
        finish_test("reset values");
    endtask

    task automatic test_register_writes();
        logic [11:0] cfg;
        logic [31:0] cic_0;
        logic [31:0] cic_1;
        logic [31:0] base;
        logic [31:0] value;
        test_errors = 0;
        cfg   = 12'($urandom);
        cic_0 = $urandom;
        cic_1 = $urandom;
        base  = $urandom & 32'hFFFF_FFFE;

        write_reg(ADDR_CFG_SCR, {20'd0, cfg});
        check_value("cfg_flags", 64'(cfg_flags), 64'(cfg));
        read_reg(ADDR_CFG_SCR, value);
        check_value("CFG_SCR", 64'(value), 64'(cfg));

        write_reg_pair(ADDR_CIC_0, cic_0, cic_1);
        check_value("cic_disabled", 64'(cic_disabled), 64'(cic_0[26]));
        check_value("cic_64dd_mode", 64'(cic_64dd_mode), 64'(cic_0[25]));
        check_value("cic_region", 64'(cic_region), 64'(cic_0[24]));
        check_value("cic_seed", 64'(cic_seed), 64'(cic_0[23:16]));
        check_value("cic_checksum", 64'(cic_checksum), 64'({cic_0[15:0], cic_1}));
        read_reg(ADDR_CIC_0, value);
        check_value("CIC_0", 64'(value), 64'(cic_0 & 32'h07FF_FFFF));
        read_reg(ADDR_CIC_1, value);
        check_value("CIC_1", 64'(value), 64'(cic_1));

        // A one word write at base proves MEM_SCR followed MEM_ADDRESS.
        run_transfer(base, 1, 1'b1);
        check_value("bus request count", 64'(bus_addr_q.size()), 64'd1);
        check_requests(base, 1'b1);
        read_reg(ADDR_MEM_ADDRESS, value);
        check_value("MEM_ADDRESS", 64'(value), 64'(base));
        finish_test("register writes");
    endtask

    task automatic pulse_nmi();
        n64_nmi = 1'b1;
        @(negedge clk);
        n64_nmi = 1'b0;
        @(negedge clk);
    endtask

    task automatic test_boot_flags();
        logic [31:0] value;
        logic [31:0] fields;
        test_errors = 0;
        write_reg(ADDR_CFG_SCR, 32'h0000_0003);    // Skip and enabled set.
        pulse_nmi();
        check_value("cfg_flags", 64'(cfg_flags), 64'h002);
        write_reg(ADDR_CFG_SCR, 32'h0000_0000);
        pulse_nmi();
        check_value("cfg_flags", 64'(cfg_flags), 64'h001);

        cic_invalid_region_in = 1'b1;
        @(negedge clk);
        cic_invalid_region_in = 1'b0;
        read_reg(ADDR_CIC_0, value);
        check_value("CIC_0 invalid region", 64'(value[28]), 64'd1);
        fields = value & ~32'h1000_0000;
        write_reg(ADDR_CIC_0, value);    // Bit 28 is set here.
        read_reg(ADDR_CIC_0, value);
        check_value("CIC_0", 64'(value), 64'(fields));
        finish_test("bootloader and CIC flags");
    endtask

    task automatic test_bus_write();
        logic [15:0] words [$];
        logic [31:0] base;
        int          k;
        test_errors = 0;
        base = $urandom & 32'hFFFF_FFFE;
        for (k = 0; k < XFER_WORDS; k++) begin
            words.push_back(16'($urandom));
        end
        write_buffer(8'd0, words);
        run_transfer(base, XFER_WORDS, 1'b1);
        check_value("bus request count", 64'(bus_addr_q.size()), 64'(XFER_WORDS));
        check_requests(base, 1'b1);
        for (k = 0; k < bus_data_q.size() && k < XFER_WORDS; k++) begin
            check_value("mem_wdata", 64'(bus_data_q[k]), 64'(words[k]));
        end
        finish_test("buffer and bus write");
    endtask

    task automatic test_bus_read_stop();
        logic [31:0] base;
        logic [31:0] value;
        int          k;
        test_errors = 0;
        base = $urandom & 32'hFFFF_FFFE;
        run_transfer(base, XFER_WORDS, 1'b0);
        check_value("bus request count", 64'(bus_addr_q.size()), 64'(XFER_WORDS));
        check_requests(base, 1'b0);
        read_buffer(8'd0, XFER_WORDS);
        for (k = 0; k < XFER_WORDS; k++) begin
            check_value("buffer word", 64'(buffer_words[k]),
                        64'(16'(base + 32'(2 * k)) ^ 16'h5A5A));
        end

        // Long read, cut short by a stop while the engine is still busy.
        clear_bus_log();
        write_reg_pair(ADDR_MEM_ADDRESS, base, scr_value(LONG_WORDS, 1'b0, 1'b0, 1'b1));
        write_reg(ADDR_MEM_SCR, scr_value(LONG_WORDS, 1'b0, 1'b1, 1'b0));
        wait_idle();
        assert (bus_addr_q.size() > 0 && bus_addr_q.size() < LONG_WORDS) else begin
            $display("Stop did not cut the transfer short, %0d of %0d words",
                     bus_addr_q.size(), LONG_WORDS);
            test_errors++;
        end
        check_requests(base, 1'b0);
        read_reg(ADDR_MEM_SCR, value);
        check_value("MEM_SCR busy", 64'(value[3]), 64'd0);
        check_value("mem_request", 64'(mem_request), 64'd0);
        finish_test("bus read and stop");
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'h149a_0a49));
        tests_run             = 0;
        failed_tests          = 0;
        test_errors           = 0;
        reset                 = 1'b1;
        frame_start           = 1'b0;
        data_ready            = 1'b0;
        rx_data               = 8'h00;
        n64_nmi               = 1'b0;
        cic_invalid_region_in = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        test_identify();
        test_reset_values();
        test_register_writes();
        test_boot_flags();
        test_bus_write();
        test_bus_read_stop();

        $display("Tests run: %0d, failed: %0d", tests_run, failed_tests);
        if (failed_tests == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
hw/mcu_bridge_pkg.sv
hw/mcu_bridge_ifs.sv
hw/mcu_cmd_decoder.sv
hw/mcu_reg_block.sv
hw/mem_buffer_ctrl.sv
hw/mcu_response_mux.sv
hw/mcu_bridge_top.sv
tb/mcu_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE="$BUILD_DIR/sim.log"

if ! mkdir -p "$BUILD_DIR"; then
    echo "Cannot create $BUILD_DIR"
    exit 1
fi

if ! verilator --binary --timing --assert -j 0 \
        --top-module mcu_bridge_tb \
        -Mdir "$BUILD_DIR/obj_dir" -o mcu_bridge_sim \
        -f all.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! "$BUILD_DIR/obj_dir/mcu_bridge_sim" > "$LOG_FILE" 2>&1; then
    cat "$LOG_FILE"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG_FILE"

if grep -q "ALL TESTS PASSED" "$LOG_FILE"; then
    exit 0
fi
exit 1
